//--- list.f
hw/raster_pkg.sv
hw/vertex_fetch.sv
hw/triangle_setup.sv
hw/edge_lane.sv
hw/fragment_collector.sv
hw/rasterizer_unit.sv
verif/vertex_memory.sv
verif/tb_rasterizer_unit.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_rasterizer_unit -f list.f -o sim_rasterizer &&
out=$(./obj_dir/sim_rasterizer) &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "Test passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

exit 0

//--- verif/tb_rasterizer_unit.sv
`timescale 1ns/1ps

module tb_rasterizer_unit;

    localparam int LANES      = 4;
    localparam int ADDR_W     = 26;
    localparam int JOBS       = 5;
    localparam int WAIT_LIMIT = 5000;

    typedef struct packed {
        logic [ADDR_W-1:0]           base;
        logic [15:0]                 count;
        raster_pkg::triangle_t [3:0] tris;
    } job_t;

    logic               clock;
    logic               reset;
    logic               start;
    logic [ADDR_W-1:0]  list_addr;
    logic               busy;
    logic [ADDR_W-1:0]  mem_address;
    logic               mem_read;
    logic               mem_waitrequest;
    logic [31:0]        mem_readdata;
    logic               mem_readdatavalid;
    logic               frag_valid;
    raster_pkg::coord_t frag_x;
    raster_pkg::coord_t frag_y;
    logic [LANES-1:0]   frag_mask;
    logic               frag_last;
    logic               tri_done;
    logic [31:0]        tri_pixels;
    logic               load_en;
    logic [ADDR_W-1:0]  load_addr;
    logic [31:0]        load_data;

    raster_pkg::coord_t exp_x [$];
    raster_pkg::coord_t exp_y [$];
    logic [LANES-1:0]   exp_mask [$];
    logic               exp_last [$];
    logic [31:0]        exp_pixels [$];
    logic [ADDR_W-1:0]  exp_addr [$];
    logic [ADDR_W-1:0]  got_addr [$];
    logic               held_read;
    logic [ADDR_W-1:0]  held_addr;
    int                 errors;
    int                 spans_seen;
    int                 tris_seen;

    rasterizer_unit #(.LANES(LANES), .ADDR_W(ADDR_W)) dut0 (
        .clock             (clock),
        .reset             (reset),
        .start             (start),
        .list_addr         (list_addr),
        .busy              (busy),
        .mem_address       (mem_address),
        .mem_read          (mem_read),
        .mem_waitrequest   (mem_waitrequest),
        .mem_readdata      (mem_readdata),
        .mem_readdatavalid (mem_readdatavalid),
        .frag_valid        (frag_valid),
        .frag_x            (frag_x),
        .frag_y            (frag_y),
        .frag_mask         (frag_mask),
        .frag_last         (frag_last),
        .tri_done          (tri_done),
        .tri_pixels        (tri_pixels)
    );

    vertex_memory #(.ADDR_W(ADDR_W)) mem0 (
        .clock         (clock),
        .reset         (reset),
        .address       (mem_address),
        .read          (mem_read),
        .waitrequest   (mem_waitrequest),
        .readdata      (mem_readdata),
        .readdatavalid (mem_readdatavalid),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic raster_pkg::triangle_t make_tri(int x0, int y0, int x1, int y1,
                                                       int x2, int y2);
        raster_pkg::triangle_t t;
        t.v0.x = 16'(x0);
        t.v0.y = 16'(y0);
        t.v1.x = 16'(x1);
        t.v1.y = 16'(y1);
        t.v2.x = 16'(x2);
        t.v2.y = 16'(y2);
        return t;
    endfunction

    // edge p->q evaluated at (x, y) in wide signed arithmetic.
    function automatic longint edge_value(raster_pkg::vertex_t p, raster_pkg::vertex_t q,
                                          int x, int y);
        longint a;
        longint b;
        longint c;
        a = longint'(p.y) - longint'(q.y);
        b = longint'(q.x) - longint'(p.x);
        c = longint'(p.x) * longint'(q.y) - longint'(q.x) * longint'(p.y);
        return a * longint'(x) + b * longint'(y) + c;
    endfunction

    function automatic bit covers(raster_pkg::triangle_t t, int x, int y);
        longint e0;
        longint e1;
        longint e2;
        e0 = edge_value(t.v0, t.v1, x, y);
        e1 = edge_value(t.v1, t.v2, x, y);
        e2 = edge_value(t.v2, t.v0, x, y);
        return ((e0 >= 0) && (e1 >= 0) && (e2 >= 0)) || ((e0 <= 0) && (e1 <= 0) && (e2 <= 0));
    endfunction

    function automatic int smallest(int a, int b, int c);
        int m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic int largest(int a, int b, int c);
        int m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // spans run row by row from the box corner, LANES pixels at a time.
    task automatic predict_triangle(input raster_pkg::triangle_t t);
        int               min_x;
        int               max_x;
        int               min_y;
        int               max_y;
        int               x;
        int               y;
        int               i;
        int               pixels;
        logic [LANES-1:0] mask;
        min_x  = smallest(int'(t.v0.x), int'(t.v1.x), int'(t.v2.x));
        max_x  = largest(int'(t.v0.x), int'(t.v1.x), int'(t.v2.x));
        min_y  = smallest(int'(t.v0.y), int'(t.v1.y), int'(t.v2.y));
        max_y  = largest(int'(t.v0.y), int'(t.v1.y), int'(t.v2.y));
        pixels = 0;
        for (y = min_y; y <= max_y; y++) begin
            for (x = min_x; x <= max_x; x += LANES) begin
                mask = '0;
                for (i = 0; i < LANES; i++) begin
                    if ((x + i <= max_x) && covers(t, x + i, y)) begin
                        mask[i] = 1'b1;
                        pixels++;
                    end
                end
                exp_x.push_back(16'(x));
                exp_y.push_back(16'(y));
                exp_mask.push_back(mask);
                exp_last.push_back((y == max_y) && (x + LANES > max_x));
            end
        end
        exp_pixels.push_back(32'(pixels));
    endtask

    ////////////////////////////////////////////////////////////
    // checks and output monitor
    ////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_span();
        raster_pkg::coord_t want_x;
        raster_pkg::coord_t want_y;
        logic [LANES-1:0]   want_mask;
        logic               want_last;
        if (exp_x.size() == 0) begin
            $display("fragment at (%0d, %0d) arrived with no span expected", frag_x, frag_y);
            errors++;
        end else begin
            want_x    = exp_x.pop_front();
            want_y    = exp_y.pop_front();
            want_mask = exp_mask.pop_front();
            want_last = exp_last.pop_front();
            spans_seen++;
            check("frag_x", 64'(frag_x), 64'(want_x));
            check("frag_y", 64'(frag_y), 64'(want_y));
            check("frag_mask", 64'(frag_mask), 64'(want_mask));
            check("frag_last", 64'(frag_last), 64'(want_last));
            check("tri_done", 64'(tri_done), 64'(want_last));
            check("busy", 64'(busy), 64'd1);
            if (want_last) begin
                tris_seen++;
                check("tri_pixels", 64'(tri_pixels), 64'(exp_pixels.pop_front()));
            end
        end
    endtask

    // outputs settle between edges, so everything is sampled on the falling edge.
    always @(negedge clock) begin
        if (reset) begin
            if (held_read) begin
                check("mem_read", 64'(mem_read), 64'd1);
                check("mem_address", 64'(mem_address), 64'(held_addr));
            end
            held_read = mem_read && mem_waitrequest;
            held_addr = mem_address;
            if (mem_read && !mem_waitrequest) begin
                got_addr.push_back(mem_address);
            end
            if (frag_valid) begin
                check_span();
            end else if (tri_done) begin
                $display("tri_done arrived without a fragment");
                errors++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // job sequencing
    ////////////////////////////////////////////////////////////

    task automatic run_job(input job_t job, output bit ok);
        logic [31:0] words [$];
        int          k;
        int          t;
        words.push_back({16'h0000, job.count});
        for (k = 0; k < int'(job.count); k++) begin
            words.push_back(job.tris[k].v0);
            words.push_back(job.tris[k].v1);
            words.push_back(job.tris[k].v2);
            predict_triangle(job.tris[k]);
        end
        for (k = 0; k < words.size(); k++) begin
            @(negedge clock);
            load_en   = 1'b1;
            load_addr = job.base + ADDR_W'(k);
            load_data = words[k];
            exp_addr.push_back(job.base + ADDR_W'(k));
        end
        @(negedge clock);
        load_en = 1'b0;
        got_addr.delete();
        start     = 1'b1;
        list_addr = job.base;
        @(negedge clock);
        start = 1'b0;
        check("busy", 64'(busy), 64'd1);
        check("mem_read", 64'(mem_read), 64'd1);
        t = 0;
        while (busy && t < WAIT_LIMIT) begin
            @(negedge clock);
            t++;
        end
        ok = !busy;
        if (busy) begin
            $display("busy stayed high for %0d cycles on the job at 0x%0h", t, job.base);
            errors++;
        end else begin
            check("read count", 64'(got_addr.size()), 64'(exp_addr.size()));
            for (k = 0; k < got_addr.size() && k < exp_addr.size(); k++) begin
                check("mem_address", 64'(got_addr[k]), 64'(exp_addr[k]));
            end
            check("spans left", 64'(exp_x.size()), 64'd0);
            check("triangles left", 64'(exp_pixels.size()), 64'd0);
        end
        exp_addr.delete();
    endtask

    initial begin
        job_t jobs [JOBS];
        bit   ok;
        int   j;
        reset      = 1'b0;
        start      = 1'b0;
        list_addr  = '0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        held_read  = 1'b0;
        held_addr  = '0;
        errors     = 0;
        spans_seen = 0;
        tris_seen  = 0;
        void'($urandom(32'hb491b31b));

        // one triangle each way round, then an empty list, then four in a row.
        jobs[0]         = '0;
        jobs[0].base    = 26'd16;
        jobs[0].count   = 16'd1;
        jobs[0].tris[0] = make_tri(10, 10, 20, 12, 14, 19);
        jobs[1]         = '0;
        jobs[1].base    = 26'd100;
        jobs[1].count   = 16'd1;
        jobs[1].tris[0] = make_tri(10, 10, 14, 19, 20, 12);
        jobs[2]         = '0;
        jobs[2].base    = 26'd200;
        jobs[2].count   = 16'd0;
        jobs[3]         = '0;
        jobs[3].base    = 26'd300;
        jobs[3].count   = 16'd4;
        jobs[3].tris[0] = make_tri(0, 0, 7, 0, 0, 5);
        jobs[3].tris[1] = make_tri(30, 40, 25, 46, 37, 44);
        jobs[3].tris[2] = make_tri(5, 5, 6, 9, 9, 6);
        jobs[3].tris[3] = make_tri(100, 3, 103, 3, 101, 4);
        // a flat triangle covers its whole line, so only the box edge masks the lane past it.
        jobs[4]         = '0;
        jobs[4].base    = 26'd400;
        jobs[4].count   = 16'd1;
        jobs[4].tris[0] = make_tri(50, 20, 52, 20, 51, 20);

        repeat (3) @(negedge clock);
        reset = 1'b1;
        ok    = 1'b1;
        for (j = 0; j < JOBS && ok; j++) begin
            run_job(jobs[j], ok);
            @(negedge clock);
        end

        $display("spans checked %0d, triangles checked %0d, errors %0d",
                 spans_seen, tris_seen, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verif/vertex_memory.sv
`timescale 1ns/1ps

module vertex_memory #(
    parameter int ADDR_W = 26,
    parameter int DEPTH  = 1024
) (
    input  logic              clock,
    input  logic              reset,
    input  logic [ADDR_W-1:0] address,
    input  logic              read,
    output logic              waitrequest,
    output logic [31:0]       readdata,
    output logic              readdatavalid,
    input  logic              load_en,
    input  logic [ADDR_W-1:0] load_addr,
    input  logic [31:0]       load_data
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [31:0]      words [DEPTH];
    logic [1:0]       wait_left;
    logic [1:0]       valid_pipe;
    logic [IDX_W-1:0] addr_q;

    // unwritten words carry their index in the low half and its inverse in the high half.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            words[i] = {~16'(i), 16'(i)};
        end
    end

    // the wait count for the next read is drawn when the current one is accepted.
    assign waitrequest   = read && (wait_left != 2'd0);
    assign readdatavalid = valid_pipe[1];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wait_left  <= 2'd0;
            valid_pipe <= 2'b00;
        end else begin
            valid_pipe <= {valid_pipe[0], read && !waitrequest};
            if (read && waitrequest) begin
                wait_left <= wait_left - 1'b1;
            end else if (read) begin
                wait_left <= 2'($urandom % 4);
            end
        end
    end

    always @(posedge clock) begin
        if (read && !waitrequest) begin
            addr_q <= address[IDX_W-1:0];
        end
        if (valid_pipe[0]) begin
            readdata <= words[addr_q];
        end
        if (load_en) begin
            words[load_addr[IDX_W-1:0]] <= load_data;
        end
    end

endmodule

//--- hw/rasterizer_unit.sv
`timescale 1ns/1ps

module rasterizer_unit #(
    parameter int LANES  = 4,
    parameter int ADDR_W = 26
) (
    input  logic               clock,
    input  logic               reset,

    input  logic               start,
    input  logic [ADDR_W-1:0]  list_addr,
    output logic               busy,

    output logic [ADDR_W-1:0]  mem_address,
    output logic               mem_read,
    input  logic               mem_waitrequest,
    input  logic [31:0]        mem_readdata,
    input  logic               mem_readdatavalid,

    output logic               frag_valid,
    output raster_pkg::coord_t frag_x,
    output raster_pkg::coord_t frag_y,
    output logic [LANES-1:0]   frag_mask,
    output logic               frag_last,
    output logic               tri_done,
    output logic [31:0]        tri_pixels
);

    logic                  tri_valid;
    raster_pkg::triangle_t tri_data;
    logic                  setup_idle;
    logic                  span_valid;
    raster_pkg::span_t     span;
    logic [LANES-1:0]      lane_valid;
    logic [LANES-1:0]      lane_hit;
    logic [LANES-1:0]      lane_last;
    raster_pkg::coord_t    lane_x [LANES];
    raster_pkg::coord_t    lane_y [LANES];

    vertex_fetch #(.ADDR_W(ADDR_W)) fetch0 (
        .clock             (clock),
        .reset             (reset),
        .start             (start),
        .list_addr         (list_addr),
        .mem_address       (mem_address),
        .mem_read          (mem_read),
        .mem_waitrequest   (mem_waitrequest),
        .mem_readdata      (mem_readdata),
        .mem_readdatavalid (mem_readdatavalid),
        .setup_idle        (setup_idle),
        .tri_done          (tri_done),
        .tri_valid         (tri_valid),
        .tri_data          (tri_data),
        .last_tri          (),
        .busy              (busy)
    );

    triangle_setup #(.LANES(LANES)) setup0 (
        .clock      (clock),
        .reset      (reset),
        .tri_valid  (tri_valid),
        .tri_data   (tri_data),
        .setup_idle (setup_idle),
        .span_valid (span_valid),
        .span       (span)
    );

    ////////////////////////////////////////////////////////////
    // one edge test per pixel of a span
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        edge_lane #(.LANES(LANES), .LANE_ID(i)) lane (
            .clock      (clock),
            .reset      (reset),
            .span_valid (span_valid),
            .span       (span),
            .hit_valid  (lane_valid[i]),
            .hit        (lane_hit[i]),
            .hit_x      (lane_x[i]),
            .hit_y      (lane_y[i]),
            .hit_last   (lane_last[i])
        );
    end

    // all lanes run in step, so lane 0 speaks for the span position.
    fragment_collector #(.LANES(LANES)) collect0 (
        .clock      (clock),
        .reset      (reset),
        .hit_valid  (lane_valid[0]),
        .hit        (lane_hit),
        .hit_x      (lane_x[0]),
        .hit_y      (lane_y[0]),
        .hit_last   (lane_last[0]),
        .frag_valid (frag_valid),
        .frag_last  (frag_last),
        .tri_done   (tri_done),
        .frag_x     (frag_x),
        .frag_y     (frag_y),
        .frag_mask  (frag_mask),
        .tri_pixels (tri_pixels)
    );

endmodule

//--- hw/fragment_collector.sv
`timescale 1ns/1ps

module fragment_collector #(
    parameter int LANES = 4
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               hit_valid,
    input  logic [LANES-1:0]   hit,
    input  raster_pkg::coord_t hit_x,
    input  raster_pkg::coord_t hit_y,
    input  logic               hit_last,
    output logic               frag_valid,
    output logic               frag_last,
    output logic               tri_done,
    output raster_pkg::coord_t frag_x,
    output raster_pkg::coord_t frag_y,
    output logic [LANES-1:0]   frag_mask,
    output logic [31:0]        tri_pixels
);

    logic [31:0] running_total;
    logic [31:0] span_count;

    function automatic logic [31:0] count_ones(logic [LANES-1:0] bits);
        logic [31:0] n;
        n = '0;
        for (int i = 0; i < LANES; i++) begin
            n = n + 32'(bits[i]);
        end
        return n;
    endfunction

    assign span_count = count_ones(hit);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            frag_valid    <= 1'b0;
            frag_last     <= 1'b0;
            tri_done      <= 1'b0;
            running_total <= '0;
        end else begin
            frag_valid <= hit_valid;
            frag_last  <= hit_valid && hit_last;
            tri_done   <= hit_valid && hit_last;
            if (hit_valid) begin
                // the total restarts with the first span of the next triangle.
                running_total <= hit_last ? 32'd0 : running_total + span_count;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (hit_valid) begin
            frag_x    <= hit_x;
            frag_y    <= hit_y;
            frag_mask <= hit;
            if (hit_last) begin
                tri_pixels <= running_total + span_count;
            end
        end
    end

endmodule

//--- hw/edge_lane.sv
`timescale 1ns/1ps

module edge_lane #(
    parameter int LANES   = 4,
    parameter int LANE_ID = 0
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               span_valid,
    input  raster_pkg::span_t  span,
    output logic               hit_valid,
    output logic               hit,
    output raster_pkg::coord_t hit_x,
    output raster_pkg::coord_t hit_y,
    output logic               hit_last
);

    localparam int IDX_W = (LANES > 1) ? $clog2(LANES) : 1;
    localparam logic [IDX_W-1:0] LANE_OFFSET = IDX_W'(LANE_ID);

    raster_pkg::coord_t px;
    logic signed [39:0] v0;
    logic signed [39:0] v1;
    logic signed [39:0] v2;
    logic               covered;

    function automatic logic signed [39:0] eval_edge(raster_pkg::edge_t e,
                                                     raster_pkg::coord_t x,
                                                     raster_pkg::coord_t y);
        logic signed [39:0] ea;
        logic signed [39:0] eb;
        logic signed [39:0] ec;
        logic signed [39:0] sx;
        logic signed [39:0] sy;
        ea = {{22{e.a[17]}}, e.a};
        eb = {{22{e.b[17]}}, e.b};
        ec = {{4{e.c[35]}}, e.c};
        sx = {24'd0, x};
        sy = {24'd0, y};
        return ea * sx + eb * sy + ec;
    endfunction

    assign px = span.x + 16'(LANE_OFFSET);

    always_comb begin
        v0 = eval_edge(span.e0, px, span.y);
        v1 = eval_edge(span.e1, px, span.y);
        v2 = eval_edge(span.e2, px, span.y);
        // both windings count, so all three may share either sign.
        covered = (px <= span.max_x) &&
                  (((v0 >= 0) && (v1 >= 0) && (v2 >= 0)) ||
                   ((v0 <= 0) && (v1 <= 0) && (v2 <= 0)));
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= span_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (span_valid) begin
            hit      <= covered;
            hit_x    <= span.x;
            hit_y    <= span.y;
            hit_last <= span.last;
        end
    end

endmodule

//--- hw/triangle_setup.sv
`timescale 1ns/1ps

module triangle_setup #(
    parameter int LANES = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  tri_valid,
    input  raster_pkg::triangle_t tri_data,
    output logic                  setup_idle,
    output logic                  span_valid,
    output raster_pkg::span_t     span
);

    localparam logic [16:0] STEP = 17'(LANES);

    raster_pkg::triangle_t tri_q;
    raster_pkg::edge_t     e0_q;
    raster_pkg::edge_t     e1_q;
    raster_pkg::edge_t     e2_q;
    raster_pkg::coord_t    min_x_q;
    raster_pkg::coord_t    max_x_q;
    raster_pkg::coord_t    max_y_q;
    raster_pkg::coord_t    box_min_x;
    raster_pkg::coord_t    box_min_y;
    raster_pkg::coord_t    box_max_x;
    raster_pkg::coord_t    box_max_y;
    raster_pkg::coord_t    cur_x;
    raster_pkg::coord_t    cur_y;
    logic                  coef_valid;
    logic                  sweeping;
    logic                  row_end;

    // edge p->q gives a = py - qy, b = qx - px, c = px*qy - qx*py.
    function automatic raster_pkg::edge_t make_edge(raster_pkg::vertex_t p,
                                                    raster_pkg::vertex_t q);
        raster_pkg::edge_t e;
        logic [31:0]       m0;
        logic [31:0]       m1;
        m0 = p.x * q.y;
        m1 = q.x * p.y;
        e.a = {2'b00, p.y} - {2'b00, q.y};
        e.b = {2'b00, q.x} - {2'b00, p.x};
        e.c = {4'b0000, m0} - {4'b0000, m1};
        return e;
    endfunction

    function automatic raster_pkg::coord_t min3(raster_pkg::coord_t a,
                                                raster_pkg::coord_t b,
                                                raster_pkg::coord_t c);
        raster_pkg::coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic raster_pkg::coord_t max3(raster_pkg::coord_t a,
                                                raster_pkg::coord_t b,
                                                raster_pkg::coord_t c);
        raster_pkg::coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    ////////////////////////////////////////////////////////////
    // coefficients, then the bounding box
    ////////////////////////////////////////////////////////////

    always_comb begin
        box_min_x = min3(tri_q.v0.x, tri_q.v1.x, tri_q.v2.x);
        box_min_y = min3(tri_q.v0.y, tri_q.v1.y, tri_q.v2.y);
        box_max_x = max3(tri_q.v0.x, tri_q.v1.x, tri_q.v2.x);
        box_max_y = max3(tri_q.v0.y, tri_q.v1.y, tri_q.v2.y);
    end

    always_ff @(posedge clock) begin
        if (tri_valid) begin
            tri_q <= tri_data;
            e0_q  <= make_edge(tri_data.v0, tri_data.v1);
            e1_q  <= make_edge(tri_data.v1, tri_data.v2);
            e2_q  <= make_edge(tri_data.v2, tri_data.v0);
        end
        if (coef_valid) begin
            min_x_q <= box_min_x;
            max_x_q <= box_max_x;
            max_y_q <= box_max_y;
        end
    end

    ////////////////////////////////////////////////////////////
    // span sweep
    ////////////////////////////////////////////////////////////

    assign row_end = ({1'b0, cur_x} + STEP) > {1'b0, max_x_q};

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            coef_valid <= 1'b0;
            sweeping   <= 1'b0;
            cur_x      <= '0;
            cur_y      <= '0;
        end else begin
            coef_valid <= tri_valid;
            if (coef_valid) begin
                cur_x    <= box_min_x;
                cur_y    <= box_min_y;
                sweeping <= 1'b1;
            end else if (sweeping) begin
                if (row_end) begin
                    if (cur_y == max_y_q) begin
                        sweeping <= 1'b0;
                    end else begin
                        cur_y <= cur_y + 1'b1;
                        cur_x <= min_x_q;
                    end
                end else begin
                    cur_x <= cur_x + STEP[15:0];
                end
            end
        end
    end

    assign setup_idle = !(coef_valid || sweeping);
    assign span_valid = sweeping;

    always_comb begin
        span.e0    = e0_q;
        span.e1    = e1_q;
        span.e2    = e2_q;
        span.x     = cur_x;
        span.y     = cur_y;
        span.max_x = max_x_q;
        span.last  = row_end && (cur_y == max_y_q);
    end

endmodule

//--- hw/vertex_fetch.sv
`timescale 1ns/1ps

module vertex_fetch #(
    parameter int ADDR_W = 26
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  logic [ADDR_W-1:0]      list_addr,
    output logic [ADDR_W-1:0]      mem_address,
    output logic                   mem_read,
    input  logic                   mem_waitrequest,
    input  raster_pkg::list_word_u mem_readdata,
    input  logic                   mem_readdatavalid,
    input  logic                   setup_idle,
    input  logic                   tri_done,
    output logic                   tri_valid,
    output raster_pkg::triangle_t  tri_data,
    output logic                   last_tri,
    output logic                   busy
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR_REQ,
        S_HDR_WAIT,
        S_VTX_REQ,
        S_VTX_WAIT,
        S_HANDOFF,
        S_DRAIN
    } state_t;

    state_t      state;
    logic [1:0]  vtx_idx;
    logic [15:0] tri_left;
    logic [15:0] done_left;

    ////////////////////////////////////////////////////////////
    // read sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state       <= S_IDLE;
            mem_address <= '0;
            mem_read    <= 1'b0;
            vtx_idx     <= '0;
            tri_left    <= '0;
            done_left   <= '0;
            tri_valid   <= 1'b0;
            last_tri    <= 1'b0;
            busy        <= 1'b0;
        end else begin
            tri_valid <= 1'b0;
            last_tri  <= 1'b0;

            // one read at a time, so address and read simply hold in a request state.
            case (state)
                S_IDLE: begin
                    if (start) begin
                        mem_address <= list_addr;
                        mem_read    <= 1'b1;
                        busy        <= 1'b1;
                        state       <= S_HDR_REQ;
                    end
                end
                S_HDR_REQ, S_VTX_REQ: begin
                    if (!mem_waitrequest) begin
                        mem_read <= 1'b0;
                        state    <= (state == S_HDR_REQ) ? S_HDR_WAIT : S_VTX_WAIT;
                    end
                end
                S_HDR_WAIT: begin
                    if (mem_readdatavalid) begin
                        tri_left  <= mem_readdata.header.tri_count;
                        done_left <= mem_readdata.header.tri_count;
                        vtx_idx   <= '0;
                        if (mem_readdata.header.tri_count == 16'd0) begin
                            busy  <= 1'b0;
                            state <= S_IDLE;
                        end else begin
                            mem_address <= mem_address + 1'b1;
                            mem_read    <= 1'b1;
                            state       <= S_VTX_REQ;
                        end
                    end
                end
                S_VTX_WAIT: begin
                    if (mem_readdatavalid) begin
                        if (vtx_idx == 2'd2) begin
                            vtx_idx <= '0;
                            state   <= S_HANDOFF;
                        end else begin
                            vtx_idx     <= vtx_idx + 1'b1;
                            mem_address <= mem_address + 1'b1;
                            mem_read    <= 1'b1;
                            state       <= S_VTX_REQ;
                        end
                    end
                end
                S_HANDOFF: begin
                    // the next triangle is fetched while the setup sweeps this one.
                    if (setup_idle) begin
                        tri_valid <= 1'b1;
                        last_tri  <= (tri_left == 16'd1);
                        tri_left  <= tri_left - 1'b1;
                        if (tri_left == 16'd1) begin
                            state <= S_DRAIN;
                        end else begin
                            mem_address <= mem_address + 1'b1;
                            mem_read    <= 1'b1;
                            state       <= S_VTX_REQ;
                        end
                    end
                end
                default: ;
            endcase

            // earlier triangles may finish while later ones are still being fetched.
            if (busy && tri_done) begin
                done_left <= done_left - 1'b1;
                if (done_left == 16'd1) begin
                    busy  <= 1'b0;
                    state <= S_IDLE;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_VTX_WAIT && mem_readdatavalid) begin
            case (vtx_idx)
                2'd0:    tri_data.v0 <= mem_readdata.vertex;
                2'd1:    tri_data.v1 <= mem_readdata.vertex;
                default: tri_data.v2 <= mem_readdata.vertex;
            endcase
        end
    end

endmodule

//--- hw/raster_pkg.sv
package raster_pkg;

    ////////////////////////////////////////////////////////////
    // pixel coordinates and list words
    ////////////////////////////////////////////////////////////

    typedef logic [15:0] coord_t;

    // x sits in the low half of a vertex word.
    typedef struct packed {
        coord_t y;
        coord_t x;
    } vertex_t;

    // the first word of a list is a header and every later word is a vertex.
    typedef union packed {
        struct packed {
            logic [15:0] unused;
            logic [15:0] tri_count;
        } header;
        vertex_t vertex;
    } list_word_u;

    typedef struct packed {
        vertex_t v2;
        vertex_t v1;
        vertex_t v0;
    } triangle_t;

    ////////////////////////////////////////////////////////////
    // edge functions and spans
    ////////////////////////////////////////////////////////////

    // the edge value at pixel (x, y) is a*x + b*y + c.
    typedef struct packed {
        logic signed [17:0] a;
        logic signed [17:0] b;
        logic signed [35:0] c;
    } edge_t;

    typedef struct packed {
        edge_t  e0;
        edge_t  e1;
        edge_t  e2;
        coord_t x;
        coord_t y;
        coord_t max_x;
        logic   last;
    } span_t;

endpackage
